// ==== verilog/fpga_consts.svh ====
/*
  control FPGA constants
  frame and register widths, register address map, 4094 lane setup
  and the auto-zero multiplexer codes
*/

`ifndef FPGA_CONSTS_SVH
`define FPGA_CONSTS_SVH

// one control byte then a 24 bit value
`define FRAME_BITS 32
`define REG_BITS   24

////////////////////////////////////////
// register address map
`define ADDR_LED     4'd7
`define ADDR_SPI_MUX 4'd8
`define ADDR_4094    4'd9
`define ADDR_AZ_CTL  4'd10
`define ADDR_MUX_HI  4'd11
// read only, completed az cycles
`define ADDR_AZ_STAT 4'd12

////////////////////////////////////////
// pass-through lanes
`define MUX_LANES   8
// lane 0 is the 4094 strobe, active hi. the rest are active lo
`define CS_POLARITY 8'b0000_0001

// az mux address, switch number minus one
`define AZ_HI_CODE 3'd3
`define AZ_LO_CODE 3'd5

`endif

// ==== verilog/fpga_pkg.sv ====
/*
  control FPGA shared types
  spi opcodes, az states and the structs passed between blocks
*/

`default_nettype none

`include "fpga_consts.svh"

package fpga_pkg;

  // spi opcode, upper nibble of the control byte
  // anything not listed decodes as nop
  typedef enum logic [3:0] {
    op_nop    = 4'd0,
    op_write  = 4'd1,
    op_read   = 4'd2,
    op_set    = 4'd3,
    op_clear  = 4'd4,
    op_toggle = 4'd5
  } spi_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_sig  = 2'd1,
    st_zero = 2'd2
  } az_state_e;

  // first byte of every frame
  typedef struct packed {
    spi_op_e    op;
    logic [3:0] addr;
  } spi_ctrl_t;

  // writable register file
  typedef struct packed {
    logic [`REG_BITS-1:0] led;
    logic [`REG_BITS-1:0] spi_mux;
    logic [`REG_BITS-1:0] r4094;
    logic [`REG_BITS-1:0] az_ctl;
    logic [`REG_BITS-1:0] mux_hi;
  } ctrl_regs_t;

  // overlay on the az_ctl register, period in clk cycles
  typedef struct packed {
    logic        enable;
    logic [6:0]  spare;
    logic [15:0] period;
  } az_ctl_t;

  // one bit per lane
  typedef struct packed {
    logic [`MUX_LANES-1:0] cs;
    logic [`MUX_LANES-1:0] sclk;
    logic [`MUX_LANES-1:0] mosi;
  } spi_lane_t;

endpackage

`default_nettype wire

// ==== verilog/spi_reg_bank.sv ====
/*
  spi register bank
  oversampled mode 0 slave. decodes control byte + 24 bit value,
  applies write/set/clear/toggle at cs release, shifts readback out
*/

`timescale 1ns/100ps
`default_nettype none

`include "fpga_consts.svh"

module spi_reg_bank
  import fpga_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sclk,
  input  logic                 cs,
  input  logic                 mosi,
  input  logic [`REG_BITS-1:0] az_count,
  output logic                 dout,
  output ctrl_regs_t           regs
);

  // [1] is the synchronized view, [2] the previous sample
  logic [2:0]             sclk_sr;
  logic [2:0]             cs_sr;
  logic [1:0]             mosi_sr;
  logic                   sclk_rise, sclk_fall, cs_rise, cs_s, mosi_s;
  logic [5:0]             bit_cnt;
  spi_ctrl_t              ctrl;
  logic [`FRAME_BITS-1:0] shreg;
  logic [`REG_BITS-1:0]   rb_shift;
  logic [`REG_BITS-1:0]   rd_val;
  logic [`REG_BITS-1:0]   val;

  assign cs_s      = cs_sr[1];
  assign mosi_s    = mosi_sr[1];
  assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
  assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
  assign cs_rise   = cs_sr[1] & ~cs_sr[2];
  assign val       = shreg[`REG_BITS-1:0];
  assign dout      = rb_shift[`REG_BITS-1];

  function automatic logic [`REG_BITS-1:0] apply_op(
    input spi_op_e              op,
    input logic [`REG_BITS-1:0] cur,
    input logic [`REG_BITS-1:0] v
  );
    case (op)
      op_write:  return v;
      op_set:    return cur | v;
      op_clear:  return cur & ~v;
      op_toggle: return cur ^ v;
      // read, nop and unknown codes
      default:   return cur;
    endcase
  endfunction

  ////////////////////////////////////////
  // pin sync, bit count, control byte
  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sr <= '0;
      cs_sr   <= '1;
      mosi_sr <= '0;
      bit_cnt <= '0;
      ctrl    <= '0;
    end else begin
      sclk_sr <= {sclk_sr[1:0], sclk};
      cs_sr   <= {cs_sr[1:0], cs};
      mosi_sr <= {mosi_sr[0], mosi};
      if (cs_s) begin
        bit_cnt <= '0;
      end else if (sclk_rise) begin
        // saturate so long frames never look like 32 bits
        if (bit_cnt != 6'h3f)
          bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt == 6'd7)
          ctrl <= spi_ctrl_t'({shreg[6:0], mosi_s});
      end
    end
  end

  // frame shift in, readback shift out
  always_ff @(posedge clk) begin
    if (!cs_s && sclk_rise)
      shreg <= {shreg[`FRAME_BITS-2:0], mosi_s};
    if (cs_s)
      rb_shift <= '0;
    else if (sclk_fall && bit_cnt == 6'd8)
      rb_shift <= rd_val;
    else if (sclk_fall && bit_cnt > 6'd8)
      rb_shift <= {rb_shift[`REG_BITS-2:0], 1'b0};
  end

  // readback source by address
  always_comb begin
    case (ctrl.addr)
      `ADDR_LED:     rd_val = regs.led;
      `ADDR_SPI_MUX: rd_val = regs.spi_mux;
      `ADDR_4094:    rd_val = regs.r4094;
      `ADDR_AZ_CTL:  rd_val = regs.az_ctl;
      `ADDR_MUX_HI:  rd_val = regs.mux_hi;
      `ADDR_AZ_STAT: rd_val = az_count;
      default:       rd_val = '0;
    endcase
  end

  ////////////////////////////////////////
  // register update on cs release, full frames only
  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '0;
    end else if (cs_rise && bit_cnt == 6'(`FRAME_BITS)) begin
      case (ctrl.addr)
        `ADDR_LED:     regs.led     <= apply_op(ctrl.op, regs.led, val);
        `ADDR_SPI_MUX: regs.spi_mux <= apply_op(ctrl.op, regs.spi_mux, val);
        `ADDR_4094:    regs.r4094   <= apply_op(ctrl.op, regs.r4094, val);
        `ADDR_AZ_CTL:  regs.az_ctl  <= apply_op(ctrl.op, regs.az_ctl, val);
        `ADDR_MUX_HI:  regs.mux_hi  <= apply_op(ctrl.op, regs.mux_hi, val);
        // az status is read only, unknown addr ignored
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_mux.sv ====
/*
  spi lane mux
  routes the mcu spi lines to selected 4094 lanes while cs2 is low
  and picks the miso source
*/

`timescale 1ns/100ps
`default_nettype none

`include "fpga_consts.svh"

module spi_mux
  import fpga_pkg::*;
(
  input  logic                  cs2,
  input  logic                  sclk,
  input  logic                  mosi,
  input  logic                  cs,
  input  logic [`MUX_LANES-1:0] sel,
  input  logic                  bank_dout,
  input  logic [`MUX_LANES-1:0] lane_miso,
  output spi_lane_t             lanes,
  output logic                  miso
);

  // lanes live for this transfer
  logic [`MUX_LANES-1:0] act;

  // purely combinational, the 4094 clock has to follow sclk directly
  assign act = cs2 ? '0 : sel;

  ////////////////////////////////////////
  // lane outputs
  // asserted level per lane comes from the polarity vector
  // inactive lanes sit at the opposite level
  assign lanes.cs   = ~(act ^ `CS_POLARITY);
  // idle lanes keep clock and data lo
  assign lanes.sclk = act & {`MUX_LANES{sclk}};
  assign lanes.mosi = act & {`MUX_LANES{mosi}};

  ////////////////////////////////////////
  // miso source
  always_comb begin
    if (!cs)
      miso = bank_dout;
    else if (!cs2)
      miso = |(lane_miso & act);
    else
      miso = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verilog/az_modulator.sv ====
/*
  auto-zero modulator
  alternates signal and zero phases of a programmed length,
  drives az mux address and precharge switch, counts cycles
*/

`timescale 1ns/100ps
`default_nettype none

`include "fpga_consts.svh"

module az_modulator
  import fpga_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  az_ctl_t              ctl,
  output logic [2:0]           mux_az,
  output logic                 sig_pc_sw,
  output logic [`REG_BITS-1:0] az_count,
  output logic [6:0]           mon
);

  az_state_e   state;
  logic [15:0] timer;
  // last timer value of a phase
  logic [15:0] last;
  logic        phase_last;
  logic        phase_end;

  // period of 0 acts as 1
  assign last       = (ctl.period == '0) ? '0 : ctl.period - 16'd1;
  // >= so a shortened period mid phase still ends it
  assign phase_last = (timer >= last);
  assign phase_end  = (state != st_idle) && phase_last;

  ////////////////////////////////////////
  // state machine and phase timer
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      timer    <= '0;
      az_count <= '0;
    end else begin
      case (state)
        st_idle: begin
          timer <= '0;
          if (ctl.enable)
            state <= st_sig;
        end
        st_sig: begin
          if (phase_last) begin
            timer <= '0;
            // stop at the boundary when disabled
            state <= ctl.enable ? st_zero : st_idle;
          end else begin
            timer <= timer + 16'd1;
          end
        end
        st_zero: begin
          if (phase_last) begin
            timer <= '0;
            // one full sig + zero cycle done, count wraps
            az_count <= az_count + 1'b1;
            state    <= ctl.enable ? st_sig : st_idle;
          end else begin
            timer <= timer + 16'd1;
          end
        end
        default: begin
          state <= st_idle;
          timer <= '0;
        end
      endcase
    end
  end

  // outputs decoded from state. idle looks like zero phase
  assign mux_az    = (state == st_sig) ? `AZ_HI_CODE : `AZ_LO_CODE;
  assign sig_pc_sw = (state == st_sig);

  // monitor header, msb first
  assign mon = {sig_pc_sw, mux_az, phase_end, state};

endmodule

`default_nettype wire

// ==== verilog/fpga_top.sv ====
/*
  precision voltmeter control FPGA top
  spi register bank, 4094 lane mux and az modulator on one clock
*/

`timescale 1ns/100ps
`default_nettype none

`include "fpga_consts.svh"

module fpga_top
  import fpga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // mcu spi
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_cs2,
  input  logic       spi_mosi,
  output logic       spi_miso,
  output logic       led,
  // 4094 bus, lane 0
  output logic       oe_4094,
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe,
  input  logic       glb_4094_miso,
  // analog muxes
  output logic [5:0] mux_hi,
  output logic [2:0] mux_az,
  output logic       sig_pc_sw,
  output logic [6:0] mon
);

  ctrl_regs_t           regs;
  spi_lane_t            lanes;
  logic                 bank_dout;
  logic [`REG_BITS-1:0] az_count;

  ////////////////////////////////////////
  // register bank, decode
  spi_reg_bank i_spi_reg_bank (
    .clk      (clk),
    .reset    (reset),
    .sclk     (spi_clk),
    .cs       (spi_cs),
    .mosi     (spi_mosi),
    .az_count (az_count),
    .dout     (bank_dout),
    .regs     (regs)
  );

  // lane mux, only lane 0 is wired on this board
  spi_mux i_spi_mux (
    .cs2       (spi_cs2),
    .sclk      (spi_clk),
    .mosi      (spi_mosi),
    .cs        (spi_cs),
    .sel       (regs.spi_mux[`MUX_LANES-1:0]),
    .bank_dout (bank_dout),
    .lane_miso ({{(`MUX_LANES-1){1'b0}}, glb_4094_miso}),
    .lanes     (lanes),
    .miso      (spi_miso)
  );

  ////////////////////////////////////////
  // az modulator
  az_modulator i_az_modulator (
    .clk       (clk),
    .reset     (reset),
    .ctl       (az_ctl_t'(regs.az_ctl)),
    .mux_az    (mux_az),
    .sig_pc_sw (sig_pc_sw),
    .az_count  (az_count),
    .mon       (mon)
  );

  // 4094 lane
  assign glb_4094_strobe = lanes.cs[0];
  assign glb_4094_clk    = lanes.sclk[0];
  assign glb_4094_data   = lanes.mosi[0];

  // static outputs
  assign oe_4094 = regs.r4094[0];
  assign led     = regs.led[0];
  assign mux_hi  = regs.mux_hi[5:0];

endmodule

`default_nettype wire

// ==== sim/fpga_top_chk.sv ====
/*
  control FPGA assertions
  az mux codes, precharge switch, chip select use and 4094 strobe
*/

`timescale 1ns/100ps
`default_nettype none

`include "fpga_consts.svh"

module fpga_top_chk (
  input logic       clk,
  input logic       reset,
  input logic       spi_cs,
  input logic       spi_cs2,
  input logic [2:0] mux_az,
  input logic       sig_pc_sw,
  input logic       glb_4094_strobe
);

  // only the two az codes ever reach the analog mux
  a_az_code: assert property (@(posedge clk) disable iff (reset)
    mux_az == `AZ_HI_CODE || mux_az == `AZ_LO_CODE)
    else $error("mux_az holds a code outside the two auto-zero codes");

  // precharge switch closed only in the signal phase
  a_pc_sw: assert property (@(posedge clk) disable iff (reset)
    sig_pc_sw |-> mux_az == `AZ_HI_CODE)
    else $error("sig_pc_sw is on while mux_az is not the signal code");

  // the mcu never selects both targets at once
  a_cs_excl: assert property (@(posedge clk) disable iff (reset)
    !(!spi_cs && !spi_cs2))
    else $error("spi_cs and spi_cs2 are low together");

  a_strobe: assert property (@(posedge clk) disable iff (reset)
    spi_cs2 |-> !glb_4094_strobe)
    else $error("4094 strobe asserted while spi_cs2 is high");

endmodule

bind fpga_top fpga_top_chk i_fpga_top_chk (
  .clk             (clk),
  .reset           (reset),
  .spi_cs          (spi_cs),
  .spi_cs2         (spi_cs2),
  .mux_az          (mux_az),
  .sig_pc_sw       (sig_pc_sw),
  .glb_4094_strobe (glb_4094_strobe)
);

`default_nettype wire

// ==== sim/fpga_top_tb.sv ====
/*
  control FPGA testbench
  golden spi frames, random set/clear/toggle, 4094 lane routing
  and auto-zero phase timing
*/

`timescale 1ns/100ps
`default_nettype none

`include "fpga_consts.svh"

module fpga_top_tb
  import fpga_pkg::*;
();

  localparam int SCLK_CLKS  = 16;
  localparam int RAND_OPS   = 6;
  localparam int AZ_PERIOD  = 5;
  localparam int AZ_CYCLES  = 4;
  localparam int GOLDEN_MAX = 20;
  // gap, bits, cs hold and register update
  localparam int FRAME_CLKS = 8 + `FRAME_BITS * SCLK_CLKS + 7;
  // golden, random plus final reads, short, lane, oe and az frames
  localparam int N_FRAMES   = GOLDEN_MAX + 2 * (RAND_OPS + 1) + 8;
  localparam int CS2_CLKS   = 8 + 8 * SCLK_CLKS / 2;
  localparam int AZ_CLKS    = 2 * AZ_PERIOD * (AZ_CYCLES + 3) + 2;
  localparam int RUN_LIMIT  =
    (10 + N_FRAMES * FRAME_CLKS + 2 * CS2_CLKS + AZ_CLKS) * 3 / 2;

  logic       clk, reset;
  logic       spi_clk, spi_cs, spi_cs2, spi_mosi, spi_miso;
  logic       led, oe_4094, sig_pc_sw;
  logic       glb_4094_clk, glb_4094_data, glb_4094_strobe, glb_4094_miso;
  logic [5:0] mux_hi;
  logic [2:0] mux_az;
  logic [6:0] mon;

  // register model indexed by address
  logic [`REG_BITS-1:0] shadow [16];
  logic [31:0]          rng = 32'h591d75aa;
  int                   cycles = 0;
  int                   sig_rises = 0;
  logic                 sig_prev = 1'b0;

  fpga_top i_fpga_top (
    .clk (clk), .reset (reset),
    .spi_clk (spi_clk), .spi_cs (spi_cs), .spi_cs2 (spi_cs2),
    .spi_mosi (spi_mosi), .spi_miso (spi_miso), .led (led),
    .oe_4094 (oe_4094), .glb_4094_clk (glb_4094_clk),
    .glb_4094_data (glb_4094_data), .glb_4094_strobe (glb_4094_strobe),
    .glb_4094_miso (glb_4094_miso), .mux_hi (mux_hi), .mux_az (mux_az),
    .sig_pc_sw (sig_pc_sw), .mon (mon)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > RUN_LIMIT) begin
      $display("timeout: run still going after %0d clock cycles", RUN_LIMIT);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  // precharge switch rising edges, sampled mid cycle
  always @(negedge clk) begin
    sig_prev <= sig_pc_sw;
    if (sig_pc_sw === 1'b1 && sig_prev === 1'b0)
      sig_rises <= sig_rises + 1;
  end

  ////////////////////////////////////////
  // helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // inputs change 10 ns after the edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic check(input string name, input logic [31:0] exp,
                       input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic model_op(input logic [3:0] op, input logic [3:0] addr,
                          input logic [`REG_BITS-1:0] val);
    logic [`REG_BITS-1:0] cur;
    cur = shadow[addr];
    // status and unknown addresses take no writes
    if (addr < `ADDR_LED || addr > `ADDR_MUX_HI)
      return;
    if (op == op_write)
      shadow[addr] = val;
    else if (op == op_set)
      shadow[addr] = cur | val;
    else if (op == op_clear)
      shadow[addr] = cur & ~val;
    else if (op == op_toggle)
      shadow[addr] = cur ^ val;
  endtask

  // mode 0, msb first, readback after the control byte
  task automatic spi_frame(input logic [3:0] op, input logic [3:0] addr,
                           input logic [`REG_BITS-1:0] val, input int nbits,
                           output logic [`REG_BITS-1:0] rb);
    logic [`FRAME_BITS-1:0] word;
    int                     i;
    word = {op, addr, val};
    rb   = '0;
    wait_clks(8);
    spi_cs = 1'b0;
    for (i = 0; i < nbits; i++) begin
      spi_mosi = word[`FRAME_BITS-1-i];
      wait_clks(SCLK_CLKS / 2);
      if (i >= 8)
        rb = {rb[`REG_BITS-2:0], spi_miso};
      spi_clk = 1'b1;
      wait_clks(SCLK_CLKS / 2);
      spi_clk = 1'b0;
    end
    wait_clks(4);
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    // two sync flops plus the update register
    wait_clks(3);
  endtask

  task automatic frame_check(input string name, input logic [3:0] op,
                             input logic [3:0] addr, input logic [`REG_BITS-1:0] val,
                             input logic [`REG_BITS-1:0] exp_rb);
    logic [`REG_BITS-1:0] rb;
    spi_frame(op, addr, val, `FRAME_BITS, rb);
    check(name, exp_rb, rb);
    model_op(op, addr, val);
  endtask

  // cs2 transfer, lane 0 either selected or not
  task automatic lane_transfer(input logic [7:0] data, input logic sel);
    int   i;
    logic b;
    spi_cs2 = 1'b0;
    wait_clks(4);
    check("lane strobe", sel, glb_4094_strobe);
    for (i = 0; i < 8; i++) begin
      b             = data[7-i];
      spi_mosi      = b;
      glb_4094_miso = ~b;
      wait_clks(4);
      check("lane data", sel & b, glb_4094_data);
      check("lane miso", sel & ~b, spi_miso);
      spi_clk = 1'b1;
      wait_clks(4);
      check("lane clock", sel, glb_4094_clk);
      spi_clk = 1'b0;
    end
    spi_cs2  = 1'b1;
    spi_mosi = 1'b0;
    wait_clks(4);
    check("lane strobe idle", 1'b0, glb_4094_strobe);
  endtask

  ////////////////////////////////////////
  // test sequence
  initial begin
    int                   fd, n, line_no, k, r, hi_cnt, lo_cnt, seen;
    logic [8*100-1:0]     line;
    logic [31:0]          g_op, g_addr, g_val, g_exp;
    logic [`REG_BITS-1:0] rb;
    logic [3:0]           op, addr;
    reset         = 1'b1;
    spi_clk       = 1'b0;
    spi_cs        = 1'b1;
    spi_cs2       = 1'b1;
    spi_mosi      = 1'b0;
    glb_4094_miso = 1'b0;
    foreach (shadow[i])
      shadow[i] = '0;
    wait_clks(10);
    reset = 1'b0;

    // golden frames
    fd = $fopen("sim/fpga_top_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden stimulus file sim/fpga_top_golden.txt");
      $display("FAIL: see errors above");
      $fatal(1, "missing stimulus file");
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = '0;
      n    = $fgets(line, fd);
      line_no++;
      // header lines give no hex fields
      if (n > 0 && $sscanf(line, "%h %h %h %h", g_op, g_addr, g_val, g_exp) == 4)
        frame_check($sformatf("golden line %0d", line_no), g_op[3:0], g_addr[3:0],
                    g_val[`REG_BITS-1:0], g_exp[`REG_BITS-1:0]);
    end
    $fclose(fd);

    // random set, clear, toggle on led and mux_hi
    for (r = 0; r < 2; r++) begin
      addr = (r == 0) ? `ADDR_LED : `ADDR_MUX_HI;
      for (k = 0; k < RAND_OPS; k++) begin
        rng = xorshift(rng);
        case (rng[31:24] % 3)
          0:       op = op_set;
          1:       op = op_clear;
          default: op = op_toggle;
        endcase
        frame_check($sformatf("random op %0d addr %0d", k, addr), op, addr,
                    rng[`REG_BITS-1:0], shadow[addr]);
        check("led pin", shadow[`ADDR_LED][0], led);
        check("mux_hi pins", shadow[`ADDR_MUX_HI][5:0], mux_hi);
      end
      frame_check("random final read", op_read, addr, 24'h0, shadow[addr]);
    end

    // frame cut at 20 bits is dropped
    spi_frame(op_write, `ADDR_LED, ~shadow[`ADDR_LED], 20, rb);
    check("short frame led pin", shadow[`ADDR_LED][0], led);
    frame_check("short frame read", op_read, `ADDR_LED, 24'h0, shadow[`ADDR_LED]);

    // 4094 output enable follows bit 0
    check("oe_4094 pin low", shadow[`ADDR_4094][0], oe_4094);
    frame_check("oe set", op_set, `ADDR_4094, 24'h000001, shadow[`ADDR_4094]);
    check("oe_4094 pin high", shadow[`ADDR_4094][0], oe_4094);

    // 4094 lane routing
    frame_check("lane select", op_write, `ADDR_SPI_MUX, 24'h000001,
                shadow[`ADDR_SPI_MUX]);
    lane_transfer(8'hc5, 1'b1);
    frame_check("lane deselect", op_clear, `ADDR_SPI_MUX, 24'h000001,
                shadow[`ADDR_SPI_MUX]);
    lane_transfer(8'h3a, 1'b0);

    ////////////////////////////////////////
    // auto-zero phases
    frame_check("az enable", op_write, `ADDR_AZ_CTL, {1'b1, 7'd0, 16'(AZ_PERIOD)},
                shadow[`ADDR_AZ_CTL]);
    while (sig_pc_sw !== 1'b1)
      wait_clks(1);
    for (k = 0; k < AZ_CYCLES; k++) begin
      hi_cnt = 0;
      while (sig_pc_sw === 1'b1) begin
        check("az sig code", `AZ_HI_CODE, mux_az);
        check("az sig state", st_sig, mon[1:0]);
        // phase end strobe on the last clock of the phase
        check("az sig strobe", hi_cnt == AZ_PERIOD - 1, mon[2]);
        hi_cnt++;
        wait_clks(1);
      end
      lo_cnt = 0;
      while (sig_pc_sw === 1'b0) begin
        check("az zero code", `AZ_LO_CODE, mux_az);
        check("az zero state", st_zero, mon[1:0]);
        check("az zero strobe", lo_cnt == AZ_PERIOD - 1, mon[2]);
        lo_cnt++;
        wait_clks(1);
      end
      check("az sig length", AZ_PERIOD, hi_cnt);
      check("az zero length", AZ_PERIOD, lo_cnt);
    end
    frame_check("az disable", op_clear, `ADDR_AZ_CTL, 24'h800000, shadow[`ADDR_AZ_CTL]);
    wait_clks(2 * AZ_PERIOD + 2);
    check("az idle switch", 0, sig_pc_sw);
    check("az idle code", `AZ_LO_CODE, mux_az);
    check("az idle state", st_idle, mon[1:0]);
    check("az idle strobe", 0, mon[2]);
    // last sig phase may go idle with no zero phase after it
    seen = sig_rises - 1;
    check("az cycles seen", 1, seen >= AZ_CYCLES);
    spi_frame(op_read, `ADDR_AZ_STAT, 24'h0, `FRAME_BITS, rb);
    check("az count range", 1, (rb >= seen) && (rb <= seen + 1));

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/fpga_top_golden.txt ====
# hex columns: opcode address value expected_readback
# readback is the register value before the frame's op
2 7 000000 000000
2 c 000000 000000
1 7 a5c3e1 000000
2 7 000000 a5c3e1
1 9 123456 000000
3 9 0f0000 123456
4 9 000050 1f3456
2 9 000000 1f3406
1 a 00beef 000000
5 a 0000ff 00beef
2 a 000000 00be10
1 b 00003f 000000
1 3 777777 000000
2 3 000000 000000
1 c 00ffff 000000
2 c 000000 000000
0 b ffffff 00003f

// ==== compile.f ====
+incdir+verilog
verilog/fpga_pkg.sv
verilog/spi_reg_bank.sv
verilog/spi_mux.sv
verilog/az_modulator.sv
verilog/fpga_top.sv
sim/fpga_top_chk.sv
sim/fpga_top_tb.sv

// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = fpga_top_tb
FLIST   = compile.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
SRCS    = $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)
PASS    = PASS: all tests

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
